//--- hw/fpAddPkg.sv
// Floating-point adder package with the binary32 word view and format constants
`default_nettype none

package fpAddPkg;

    // Field widths of the binary32 format
    localparam int expWidth  = 8;
    localparam int fracWidth = 23;
    localparam int wordWidth = 1 + expWidth + fracWidth;

    // Hidden bit, fraction, then guard, round and sticky
    localparam int extMantWidth = fracWidth + 4;

    // Special exponents
    localparam int expZero = 0;
    // All-ones exponent marks infinity on overflow
    localparam int expMax  = 255;

    // One binary32 word, seen as raw bits or as its fields
    typedef union packed
    {
        logic [wordWidth-1:0] bits;
        struct packed
        {
            logic                 sign;
            logic [expWidth-1:0]  exponent;
            logic [fracWidth-1:0] fraction;
        } fields;
    } floatWord;

endpackage

`default_nettype wire

//--- hw/fpAlign.sv
// Operand alignment that orders both operands by magnitude and shifts the smaller one
`default_nettype none

module fpAlign
(
    input  wire fpAddPkg::floatWord                 a,
    input  wire fpAddPkg::floatWord                 b,
    output logic [fpAddPkg::extMantWidth-1:0]       bigMant,
    output logic [fpAddPkg::extMantWidth-1:0]       smallMant,
    output logic [fpAddPkg::expWidth-1:0]           bigExp,
    output logic                                    bigSign,
    output logic                                    effSubtract
);
    import fpAddPkg::*;

    logic                      aZero;
    logic                      bZero;
    logic [fracWidth:0]        mantA;
    logic [fracWidth:0]        mantB;
    logic [wordWidth-2:0]      magA;
    logic [wordWidth-2:0]      magB;
    logic                      aIsBig;
    logic [expWidth-1:0]       smallExp;
    logic [expWidth-1:0]       expDiff;
    logic [extMantWidth-1:0]   smallExt;
    logic [extMantWidth-1:0]   shiftedSmall;
    logic [extMantWidth-1:0]   lostMask;

    // Subnormals count as zero, so the fraction is dropped with them
    assign aZero = a.fields.exponent == expWidth'(expZero);
    assign bZero = b.fields.exponent == expWidth'(expZero);

    assign mantA = aZero ? '0 : {1'b1, a.fields.fraction};
    assign mantB = bZero ? '0 : {1'b1, b.fields.fraction};

    // Exponent and fraction sit next to each other, so raw bits compare as magnitude
    assign magA = aZero ? '0 : a.bits[wordWidth-2:0];
    assign magB = bZero ? '0 : b.bits[wordWidth-2:0];
    assign aIsBig = magA >= magB;

    always_comb
    begin
        if (aIsBig)
        begin
            bigMant  = {mantA, 3'b000};
            bigExp   = a.fields.exponent;
            bigSign  = a.fields.sign;
            smallExt = {mantB, 3'b000};
            smallExp = b.fields.exponent;
        end
        else
        begin
            bigMant  = {mantB, 3'b000};
            bigExp   = b.fields.exponent;
            bigSign  = b.fields.sign;
            smallExt = {mantA, 3'b000};
            smallExp = a.fields.exponent;
        end
    end

    assign expDiff = bigExp - smallExp;

    // Right shift with everything below the round bit collapsed into sticky
    always_comb
    begin
        lostMask     = ~({extMantWidth{1'b1}} << expDiff);
        shiftedSmall = smallExt >> expDiff;
        if (expDiff >= expWidth'(extMantWidth))
        begin
            smallMant = {{(extMantWidth-1){1'b0}}, |smallExt};
        end
        else
        begin
            smallMant = {shiftedSmall[extMantWidth-1:1],
                         shiftedSmall[0] | (|(smallExt & lostMask))};
        end
    end

    assign effSubtract = a.fields.sign ^ b.fields.sign;

endmodule

`default_nettype wire

//--- hw/fpMantissaAlu.sv
// Mantissa adder/subtractor working on the aligned extended mantissas
`default_nettype none

module fpMantissaAlu
(
    input  wire logic [fpAddPkg::extMantWidth-1:0]  bigMant,
    input  wire logic [fpAddPkg::extMantWidth-1:0]  smallMant,
    input  wire logic                               bigSign,
    input  wire logic                               effSubtract,
    output logic [fpAddPkg::extMantWidth-1:0]       sumMant,
    output logic                                    carryOut,
    output logic                                    sumSign
);
    import fpAddPkg::*;

    // One extra bit holds the carry of an addition
    logic [extMantWidth:0] fullSum;
    logic                  exactZero;

    // Larger minus smaller, so a subtraction never goes negative
    always_comb
    begin
        if (effSubtract)
        begin
            fullSum = {1'b0, bigMant} - {1'b0, smallMant};
        end
        else
        begin
            fullSum = {1'b0, bigMant} + {1'b0, smallMant};
        end
    end

    assign sumMant   = fullSum[extMantWidth-1:0];
    assign carryOut  = ~effSubtract & fullSum[extMantWidth];
    assign exactZero = sumMant == '0;

    // x - x gives +0 in round to nearest
    // -0 + -0 keeps the negative sign since that is not a subtraction
    always_comb
    begin
        if (effSubtract && exactZero)
        begin
            sumSign = 1'b0;
        end
        else
        begin
            sumSign = bigSign;
        end
    end

endmodule

`default_nettype wire

//--- hw/fpNormalize.sv
// Result normalization with leading-zero shift, round to nearest even and range limits
`default_nettype none

module fpNormalize
(
    input  wire logic [fpAddPkg::extMantWidth-1:0]  sumMant,
    input  wire logic                               carryOut,
    input  wire logic                               sumSign,
    input  wire logic [fpAddPkg::expWidth-1:0]      bigExp,
    output logic                                    normSign,
    output logic [fpAddPkg::expWidth-1:0]           normExp,
    output logic [fpAddPkg::fracWidth-1:0]          normFrac
);
    import fpAddPkg::*;

    localparam int countWidth = $clog2(extMantWidth + 1);

    logic [countWidth-1:0]      leadZeros;
    logic [extMantWidth-1:0]    shiftedMant;
    logic signed [expWidth+1:0] expWork;
    logic signed [expWidth+1:0] expRounded;
    logic                       lsbBit;
    logic                       guardBit;
    logic                       roundBit;
    logic                       stickyBit;
    logic                       roundUp;
    logic [fracWidth+1:0]       roundedMant;

    // Scans upward so the last hit is the highest set bit
    function automatic logic [countWidth-1:0] countLeadingZeros(
        input logic [extMantWidth-1:0] value
    );
        logic [countWidth-1:0] count;
        count = countWidth'(extMantWidth);
        for (int i = 0; i < extMantWidth; i++)
        begin
            if (value[i])
            begin
                count = countWidth'(extMantWidth - 1 - i);
            end
        end
        return count;
    endfunction

    assign leadZeros = countLeadingZeros(sumMant);

    // Bring the hidden bit back to the top of the extended mantissa
    always_comb
    begin
        if (carryOut)
        begin
            // Bit dropped on the right shift joins sticky
            shiftedMant = {1'b1, sumMant[extMantWidth-1:2], sumMant[1] | sumMant[0]};
            expWork     = $signed({2'b00, bigExp}) + (expWidth + 2)'(1);
        end
        else
        begin
            shiftedMant = sumMant << leadZeros;
            expWork     = $signed({2'b00, bigExp})
                        - $signed({{(expWidth + 2 - countWidth){1'b0}}, leadZeros});
        end
    end

    assign lsbBit    = shiftedMant[3];
    assign guardBit  = shiftedMant[2];
    assign roundBit  = shiftedMant[1];
    assign stickyBit = shiftedMant[0];

    // Round half to even
    assign roundUp     = guardBit & (roundBit | stickyBit | lsbBit);
    assign roundedMant = {1'b0, shiftedMant[extMantWidth-1:3]}
                       + {{(fracWidth + 1){1'b0}}, roundUp};

    // All-ones fraction rounding up wraps to 1.0 of the next binade
    assign expRounded = roundedMant[fracWidth+1] ? expWork + (expWidth + 2)'(1) : expWork;

    always_comb
    begin
        normSign = sumSign;
        if (!carryOut && sumMant == '0)
        begin
            normExp  = '0;
            normFrac = '0;
        end
        else if (expWork < (expWidth + 2)'(1))
        begin
            // Underflow flushes to signed zero
            normExp  = '0;
            normFrac = '0;
        end
        else if (expRounded >= (expWidth + 2)'(expMax))
        begin
            // Overflow gives signed infinity
            normExp  = expWidth'(expMax);
            normFrac = '0;
        end
        else
        begin
            normExp  = expRounded[expWidth-1:0];
            normFrac = roundedMant[fracWidth-1:0];
        end
    end

endmodule

`default_nettype wire

//--- hw/fpAdder.sv
// Binary32 adder/subtractor top level with a four-phase req/ack controller
`default_nettype none

module fpAdder
(
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               req,
    input  wire fpAddPkg::floatWord opA,
    input  wire fpAddPkg::floatWord opB,
    input  wire logic               subtract,
    output logic                    ack,
    output fpAddPkg::floatWord      result
);
    import fpAddPkg::*;

    localparam logic [1:0] stateIdle    = 2'd0;
    localparam logic [1:0] stateCompute = 2'd1;
    localparam logic [1:0] stateDone    = 2'd2;

    logic [1:0]              state;
    floatWord                opBEff;
    floatWord                opAReg;
    floatWord                opBReg;
    floatWord                resultNext;
    logic [extMantWidth-1:0] bigMant;
    logic [extMantWidth-1:0] smallMant;
    logic [expWidth-1:0]     bigExp;
    logic                    bigSign;
    logic                    effSubtract;
    logic [extMantWidth-1:0] sumMant;
    logic                    carryOut;
    logic                    sumSign;
    logic                    normSign;
    logic [expWidth-1:0]     normExp;
    logic [fracWidth-1:0]    normFrac;

    // Subtraction is addition with B's sign flipped
    assign opBEff.bits = opB.bits ^ {subtract, {(wordWidth - 1){1'b0}}};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= stateIdle;
            ack   <= 1'b0;
        end
        else
        begin
            case (state)
                stateIdle:
                begin
                    if (req)
                    begin
                        state <= stateCompute;
                    end
                end
                stateCompute:
                begin
                    state <= stateDone;
                end
                stateDone:
                begin
                    // Hold ack until the requester lets go of req
                    if (!req)
                    begin
                        ack   <= 1'b0;
                        state <= stateIdle;
                    end
                    else
                    begin
                        ack <= 1'b1;
                    end
                end
                default:
                begin
                    state <= stateIdle;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == stateIdle && req)
        begin
            opAReg <= opA;
            opBReg <= opBEff;
        end
        if (state == stateCompute)
        begin
            result <= resultNext;
        end
    end

    fpAlign fpAlign_inst
    (
        .a           (opAReg),
        .b           (opBReg),
        .bigMant     (bigMant),
        .smallMant   (smallMant),
        .bigExp      (bigExp),
        .bigSign     (bigSign),
        .effSubtract (effSubtract)
    );

    fpMantissaAlu fpMantissaAlu_inst
    (
        .bigMant     (bigMant),
        .smallMant   (smallMant),
        .bigSign     (bigSign),
        .effSubtract (effSubtract),
        .sumMant     (sumMant),
        .carryOut    (carryOut),
        .sumSign     (sumSign)
    );

    fpNormalize fpNormalize_inst
    (
        .sumMant  (sumMant),
        .carryOut (carryOut),
        .sumSign  (sumSign),
        .bigExp   (bigExp),
        .normSign (normSign),
        .normExp  (normExp),
        .normFrac (normFrac)
    );

    assign resultNext.bits = {normSign, normExp, normFrac};

    // ack only answers a request held from capture through the compute cycle
    ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req) && $past(req, 2) && $past(req, 3))
        else $error("ack rose without req held since capture");

    // Requester reads result any time ack is up
    resultHeld: assert property (@(posedge clk) disable iff (reset)
        ack |-> $stable(result))
        else $error("result changed while ack was high");

endmodule

`default_nettype wire

//--- dv/fpRefModel.svh
// Binary32 adder reference model and xorshift random generator for the testbench
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// Shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Wide sum keeps 32 bits below the fraction and jams lost bits into bit 0
function automatic logic [31:0] refAdd(input logic [31:0] a, input logic [31:0] b,
                                       input logic sub);
    logic        signA;
    logic        signB;
    logic        signBig;
    logic [30:0] magA;
    logic [30:0] magB;
    logic [30:0] magBig;
    logic [30:0] magSmall;
    logic [63:0] bigVal;
    logic [63:0] smallVal;
    logic [63:0] sum;
    logic        lost;
    logic        up;
    logic [24:0] mant;
    int          diff;
    int          msb;
    int          expo;

    signA = a[31];
    signB = b[31] ^ sub;
    // Subnormals are zero
    magA = (a[30:23] == 8'd0) ? 31'd0 : a[30:0];
    magB = (b[30:23] == 8'd0) ? 31'd0 : b[30:0];
    magBig   = (magA >= magB) ? magA : magB;
    magSmall = (magA >= magB) ? magB : magA;
    signBig  = (magA >= magB) ? signA : signB;

    bigVal   = (magBig == 31'd0) ? 64'd0 : {8'h00, 1'b1, magBig[22:0], 32'h0};
    smallVal = (magSmall == 31'd0) ? 64'd0 : {8'h00, 1'b1, magSmall[22:0], 32'h0};
    diff = int'(magBig[30:23]) - int'(magSmall[30:23]);
    if (diff >= 60)
    begin
        lost     = smallVal != 64'd0;
        smallVal = 64'd0;
    end
    else
    begin
        lost     = (smallVal & ((64'd1 << diff) - 64'd1)) != 64'd0;
        smallVal = smallVal >> diff;
    end
    smallVal[0] = smallVal[0] | lost;
    sum = (signA != signB) ? bigVal - smallVal : bigVal + smallVal;

    // Exact zero is +0 unless both operands were zeros of the same sign
    if (sum == 64'd0)
    begin
        return {(signA == signB) ? signBig : 1'b0, 31'd0};
    end
    msb = 0;
    for (int i = 0; i < 64; i++)
    begin
        if (sum[i])
        begin
            msb = i;
        end
    end
    expo = int'(magBig[30:23]) + msb - 55;
    if (msb == 56)
    begin
        sum = (sum >> 1) | (sum & 64'd1);
    end
    else
    begin
        sum = sum << (55 - msb);
    end
    if (expo < 1)
    begin
        return {signBig, 31'd0};
    end
    up   = sum[31] & ((|sum[30:0]) | sum[32]);
    mant = {1'b0, sum[55:32]} + 25'(up);
    if (mant[24])
    begin
        expo = expo + 1;
        mant = mant >> 1;
    end
    if (expo >= 255)
    begin
        return {signBig, 8'hff, 23'd0};
    end
    return {signBig, 8'(expo), mant[22:0]};
endfunction

`endif

//--- dv/fpAdderTb.sv
// Testbench for the binary32 adder with handshake, directed and random checks
`include "fpRefModel.svh"
`default_nettype none

module fpAdderTb;
    timeunit 1ns;
    timeprecision 1ps;

    import fpAddPkg::*;

    localparam int timeoutCycles = 20;

    logic        clk;
    logic        reset;
    logic        req;
    floatWord    opA;
    floatWord    opB;
    logic        subtract;
    logic        ack;
    floatWord    result;
    int          checkCount;
    int          errorCount;
    logic        timedOut;
    logic [31:0] rngState;

    fpAdder fpAdder_inst
    (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .opA      (opA),
        .opB      (opB),
        .subtract (subtract),
        .ack      (ack),
        .result   (result)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("ERROR %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    // Counts edges until ack reaches the level when sampled 1 ns after each edge
    task automatic waitForAck(input logic level, output int cycles);
        cycles = 0;
        while (!timedOut && ack !== level)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (ack !== level && cycles >= timeoutCycles)
            begin
                $display("Timeout: ack did not reach %0b within %0d cycles", level, cycles);
                timedOut = 1'b1;
            end
        end
    endtask

    task automatic doOp(input logic [31:0] a, input logic [31:0] b, input logic sub);
        logic [31:0] expected;
        int          cycles;
        expected = refAdd(a, b, sub);
        opA.bits = a;
        opB.bits = b;
        subtract = sub;
        req      = 1'b1;
        waitForAck(1'b1, cycles);
        checkCount++;
        if (!timedOut && result.bits !== expected)
        begin
            errorCount++;
            $display("ERROR result: expected %h actual %h (a %h b %h sub %0b)",
                     expected, result.bits, a, b, sub);
        end
        req = 1'b0;
        waitForAck(1'b0, cycles);
    endtask

    task automatic handshakeCheck();
        int          cycles;
        logic [31:0] held;
        for (int i = 0; i < 3; i++)
        begin
            checkValue("ack", 32'd0, {31'd0, ack});
            @(posedge clk);
            #1;
        end
        opA.bits = 32'h3f800000;
        opB.bits = 32'h40000000;
        subtract = 1'b0;
        req      = 1'b1;
        waitForAck(1'b1, cycles);
        // Sampled at the first edge, result loaded at the second, ack at the third
        checkValue("ack rise cycles", 32'd3, 32'(cycles));
        checkValue("result", refAdd(32'h3f800000, 32'h40000000, 1'b0), result.bits);
        held = result.bits;
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clk);
            #1;
            checkValue("ack", 32'd1, {31'd0, ack});
            checkValue("result", held, result.bits);
        end
        req = 1'b0;
        waitForAck(1'b0, cycles);
        checkValue("ack fall cycles", 32'd1, 32'(cycles));
    endtask

    task automatic exactArithmetic();
        doOp(32'h3f800000, 32'h40000000, 1'b0);
        doOp(32'h40a00000, 32'h40400000, 1'b1);
        doOp(32'h44800000, 32'h3e000000, 1'b0);
        doOp(32'h40a00000, 32'hc0a00000, 1'b0);
        doOp(32'hc1200000, 32'hc1200000, 1'b1);
        doOp(32'h80000000, 32'h80000000, 1'b0);
    endtask

    task automatic normalizationCases();
        // Cancellation down to the last fraction bit
        doOp(32'h3f800001, 32'h3f800000, 1'b1);
        doOp(32'h3fc00000, 32'h3fc00000, 1'b0);
        doOp(32'h7f000000, 32'h7e800000, 1'b0);
        doOp(32'h3f800000, 32'h30800000, 1'b0);
        doOp(32'h3f800000, 32'h30800000, 1'b1);
        doOp(32'hc2000000, 32'h2f000001, 1'b0);
    endtask

    task automatic roundingCases();
        doOp(32'h3f800000, 32'h33800000, 1'b0);
        doOp(32'h3f800001, 32'h33800000, 1'b0);
        doOp(32'h3f800000, 32'h33800001, 1'b0);
        doOp(32'h3f800000, 32'h33000001, 1'b1);
        doOp(32'h3fffffff, 32'h33800000, 1'b0);
    endtask

    task automatic rangeLimits();
        doOp(32'h7f7fffff, 32'h7f7fffff, 1'b0);
        doOp(32'hff7fffff, 32'h7f7fffff, 1'b1);
        doOp(32'h00800001, 32'h00800000, 1'b1);
        doOp(32'h00800000, 32'h00800001, 1'b1);
        // Subnormal next to the smallest normal would show up in the fraction
        doOp(32'h00400000, 32'h00800000, 1'b0);
        doOp(32'h80400000, 32'h00000000, 1'b0);
    endtask

    task automatic randomSweep();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        int          expB;
        for (int i = 0; i < 300; i++)
        begin
            a = nextRandom();
            b = nextRandom();
            r = nextRandom();
            a[30:23] = 8'((r[7:0] % 254) + 1);
            // Nearby exponents half the time so cancellation shows up
            if (r[16])
            begin
                expB = int'(a[30:23]) + int'(r[11:8]) - 8;
                expB = (expB < 1) ? 1 : ((expB > 254) ? 254 : expB);
            end
            else
            begin
                expB = int'(r[15:8] % 254) + 1;
            end
            b[30:23] = 8'(expB);
            doOp(a, b, r[24]);
        end
    endtask

    initial
    begin
        clk        = 1'b0;
        reset      = 1'b1;
        req        = 1'b0;
        opA.bits   = 32'd0;
        opB.bits   = 32'd0;
        subtract   = 1'b0;
        checkCount = 0;
        errorCount = 0;
        timedOut   = 1'b0;
        rngState   = 32'h05090a88;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        handshakeCheck();
        exactArithmetic();
        normalizationCases();
        roundingCases();
        rangeLimits();
        randomSweep();
        $display("Checks: %0d  Errors: %0d", checkCount, errorCount);
        if (errorCount == 0 && !timedOut)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+dv
hw/fpAddPkg.sv
hw/fpAlign.sv
hw/fpMantissaAlu.sv
hw/fpNormalize.sv
hw/fpAdder.sv
dv/fpAdderTb.sv

//--- run.sh
#!/bin/sh
# Build the adder testbench with Verilator, run it, then look for a failure in the log
verilator --binary --timing --assert -Wno-fatal --top-module fpAdderTb \
    -Mdir obj_dir -f vlog.f > sim.log 2>&1 \
    && ./obj_dir/VfpAdderTb >> sim.log 2>&1 \
    || echo "STATUS: FAIL" >> sim.log
grep -q "STATUS: PASS" sim.log || echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0
